/* hw/mil_defs.svh */
`ifndef MIL_DEFS_SVH
`define MIL_DEFS_SVH

// entries in the transmit queue.
// the producer also starts with this many credits.
`define MIL_QUEUE_DEPTH 4

// wide enough to count from zero up to a full queue.
`define MIL_CREDIT_W ($clog2(`MIL_QUEUE_DEPTH + 1))

// clk cycles from an ioClk edge strobe to the receiver's line sample.
// the transmitter moves the line one or two cycles after a strobe,
// so three keeps the sample clear of every line change.
`define MIL_RX_SAMPLE_DELAY 3

`endif

/* hw/milStd1553Pkg.sv */
package milStd1553Pkg;

	// kind of word handed to the transmitter.
	typedef enum logic [1:0] {
		WERROR,
		WDATA,
		WCOMMAND,
		WSTATUS
	} MilWordType;

	typedef struct packed {
		MilWordType dataType;
		logic [15:0] dataWord;
	} MilData;

	// command and status share the sync that starts high.
	typedef enum logic {
		SYNC_CMD,
		SYNC_DATA
	} MilSync;

	localparam int MIL_DATA_BITS = 16;

	// the sync is three bit times, six half-bits.
	localparam int MIL_SYNC_HALVES = 6;

	// half-bit levels of each sync, oldest half in the MSB.
	localparam logic [MIL_SYNC_HALVES-1:0] MIL_SYNC_CMD_HALVES = 6'b111000;
	localparam logic [MIL_SYNC_HALVES-1:0] MIL_SYNC_DATA_HALVES = 6'b000111;

endpackage

/* hw/milLinkPkg.sv */
`include "mil_defs.svh"

package milLinkPkg;

	// slot index into the transmit queue.
	typedef logic [$clog2(`MIL_QUEUE_DEPTH)-1:0] MilQueuePtr;

	// credits held by the producer; the queue counts its occupancy in the same type.
	typedef logic [`MIL_CREDIT_W-1:0] MilCredit;

	// last slot before a pointer wraps around.
	localparam MilQueuePtr MIL_QUEUE_LAST = MilQueuePtr'(`MIL_QUEUE_DEPTH - 1);

endpackage

/* hw/ioClkEdges.sv */
module ioClkEdges (
	input  logic clk,
	input  logic rst,
	input  logic ioClk,
	output logic up,
	output logic down
);

	logic ioSync1;
	logic ioSync2;
	logic ioPrev;

	// two flops into the clk domain, a third holds the last level.
	always_ff @(posedge clk) begin
		if (rst) begin
			ioSync1 <= 1'b0;
			ioSync2 <= 1'b0;
			ioPrev <= 1'b0;
		end else begin
			ioSync1 <= ioClk;
			ioSync2 <= ioSync1;
			ioPrev <= ioSync2;
		end
	end

	// one clk cycle strobes, two cycles behind the ioClk transition.
	assign up = ioSync2 && !ioPrev;
	assign down = !ioSync2 && ioPrev;

endmodule

/* hw/milTxQueue.sv */
`include "mil_defs.svh"

module milTxQueue (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       pushValid,
	input  milStd1553Pkg::MilWordType  pushType,
	input  logic [15:0]                pushWord,
	input  logic                       take,
	output milStd1553Pkg::MilData      qData,
	output logic                       qAvail,
	output logic                       credit
);
	import milStd1553Pkg::*;
	import milLinkPkg::*;

	MilData mem [`MIL_QUEUE_DEPTH];
	MilData pushData;
	MilQueuePtr wrPtr;
	MilQueuePtr rdPtr;
	MilCredit count;
	logic pop;

	assign pushData.dataType = pushType;
	assign pushData.dataWord = pushWord;

	assign qAvail = (count != '0);
	assign qData = mem[rdPtr];
	assign pop = take && qAvail;

	// the producer's credits keep pushes from ever landing on a full queue.
	always_ff @(posedge clk) begin
		if (pushValid)
			mem[wrPtr] <= pushData;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			credit <= 1'b0;
		end else begin
			if (pushValid)
				wrPtr <= (wrPtr == MIL_QUEUE_LAST) ? '0 : wrPtr + 1'b1;
			if (pop)
				rdPtr <= (rdPtr == MIL_QUEUE_LAST) ? '0 : rdPtr + 1'b1;

			case ({pushValid, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase

			// the credit goes back in the cycle the popped slot is freed.
			credit <= pop;
		end
	end

endmodule

/* hw/milTransmitter.sv */
module milTransmitter (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   up,
	input  logic                   down,
	input  logic                   enable,
	input  milStd1553Pkg::MilData  qData,
	input  logic                   qAvail,
	output logic                   take,
	output logic                   txOut,
	output logic                   nTxOut,
	output logic                   isBusy
);
	import milStd1553Pkg::*;

	typedef enum logic [3:0] {
		IDLE, LOAD, DATA, PARITY, POSTFIX1, POSTFIX2,
		L01, L02, H11, H12, H01, H02, L11, L12
	} TxState;

	TxState state;
	TxState nextState;
	MilData data;
	logic line;
	logic lineOn;
	logic parityBit;
	logic [3:0] cntr;
	logic [3:0] nextCntr;

	// both wires rest at 0 when the line is off or disabled.
	assign txOut = enable && lineOn && line;
	assign nTxOut = enable && lineOn && !line;

	assign isBusy = (state != IDLE);
	assign take = (state == LOAD);

	always_ff @(posedge clk) begin
		if (rst)
			state <= IDLE;
		else
			state <= nextState;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			line <= 1'b0;
			lineOn <= 1'b0;
		end else begin
			case (nextState)
				IDLE, POSTFIX1, POSTFIX2: begin
					line <= 1'b0;
					lineOn <= 1'b0;
				end
				L01, L02, L11, L12: begin
					line <= 1'b0;
					lineOn <= 1'b1;
				end
				H01, H02, H11, H12: begin
					line <= 1'b1;
					lineOn <= 1'b1;
				end
				DATA: begin
					lineOn <= 1'b1;
					if (up)
						line <= data.dataWord[nextCntr];
					if (down)
						line <= !data.dataWord[cntr];
				end
				PARITY: begin
					lineOn <= 1'b1;
					if (up)
						line <= parityBit;
					if (down)
						line <= !parityBit;
				end
				// load keeps the previous level for its single cycle.
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (nextState == LOAD) begin
			data <= qData;
			parityBit <= 1'b1;
		end
		// odd parity, seeded with 1 and folded over every data bit sent.
		if (nextState == DATA && up)
			parityBit <= parityBit ^ data.dataWord[nextCntr];
		if (up)
			cntr <= nextCntr;
	end

	always_comb begin
		// counts down from bit 15; wraps to 15 after bit 0.
		nextCntr = (state == DATA) ? cntr - 1'b1 : 4'd15;

		nextState = state;
		unique case (state)
			IDLE:     if (qAvail && up && enable) nextState = LOAD;
			LOAD: begin
				unique case (data.dataType)
					WERROR:   nextState = IDLE;
					WDATA:    nextState = L01;
					WCOMMAND: nextState = H01;
					WSTATUS:  nextState = H01;
				endcase
			end
			L01:      if (down) nextState = L02;
			L02:      if (down) nextState = H11;
			H11:      if (up) nextState = H12;
			H12:      if (up) nextState = DATA;
			H01:      if (down) nextState = H02;
			H02:      if (down) nextState = L11;
			L11:      if (up) nextState = L12;
			L12:      if (up) nextState = DATA;
			DATA:     if (up && nextCntr == 4'd15) nextState = PARITY;
			PARITY:   if (up) nextState = (qAvail && enable) ? LOAD : POSTFIX1;
			POSTFIX1: if (down) nextState = POSTFIX2;
			POSTFIX2: if (up) nextState = IDLE;
		endcase
	end

endmodule

/* hw/milReceiver.sv */
`include "mil_defs.svh"

module milReceiver (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   up,
	input  logic                   down,
	input  logic                   rxIn,
	input  logic                   nRxIn,
	output logic                   rxValid,
	output milStd1553Pkg::MilSync  rxSync,
	output logic [15:0]            rxWord,
	output logic                   rxParityError
);
	import milStd1553Pkg::*;

	typedef enum logic [1:0] {
		HUNT,
		BITS,
		PEND
	} RxState;

	RxState state;
	logic [`MIL_RX_SAMPLE_DELAY-1:0] upDly;
	logic [`MIL_RX_SAMPLE_DELAY-1:0] downDly;
	logic sampleUp;
	logic sampleDown;
	logic lineOk;
	logic [MIL_SYNC_HALVES-1:0] histBit;
	logic [MIL_SYNC_HALVES-1:0] histOk;
	logic [MIL_SYNC_HALVES-1:0] histBitNext;
	logic [MIL_SYNC_HALVES-1:0] histOkNext;
	logic syncCmd;
	logic syncData;
	logic syncFound;
	logic [MIL_DATA_BITS-1:0] shiftReg;
	logic parityIn;
	logic [4:0] bitCnt;

	// samples land in the middle of a half-bit.
	assign sampleUp = upDly[`MIL_RX_SAMPLE_DELAY-1];
	assign sampleDown = downDly[`MIL_RX_SAMPLE_DELAY-1];

	// a 0/0 or 1/1 pair is no Manchester level at all.
	assign lineOk = (rxIn != nRxIn);

	assign histBitNext = {histBit[MIL_SYNC_HALVES-2:0], rxIn};
	assign histOkNext = {histOk[MIL_SYNC_HALVES-2:0], lineOk};

	// a sync ends with the second half of its third bit time.
	assign syncCmd = sampleDown && (&histOkNext) && (histBitNext == MIL_SYNC_CMD_HALVES);
	assign syncData = sampleDown && (&histOkNext) && (histBitNext == MIL_SYNC_DATA_HALVES);
	assign syncFound = syncCmd || syncData;

	always_ff @(posedge clk) begin
		if (rst) begin
			upDly <= '0;
			downDly <= '0;
			histBit <= '0;
			histOk <= '0;
			bitCnt <= '0;
			state <= HUNT;
			rxValid <= 1'b0;
		end else begin
			upDly <= {upDly[`MIL_RX_SAMPLE_DELAY-2:0], up};
			downDly <= {downDly[`MIL_RX_SAMPLE_DELAY-2:0], down};
			rxValid <= 1'b0;

			// history keeps running so a back to back sync is not missed.
			if (sampleUp || sampleDown) begin
				histBit <= histBitNext;
				histOk <= histOkNext;
			end

			unique case (state)
				HUNT: begin
					if (syncFound) begin
						bitCnt <= '0;
						state <= BITS;
					end
				end
				BITS: begin
					if (sampleUp) begin
						if (!lineOk)
							state <= HUNT;
						else if (bitCnt == 5'(MIL_DATA_BITS))
							state <= PEND;
						else
							bitCnt <= bitCnt + 1'b1;
					end
				end
				// report once the parity bit time is over.
				PEND: begin
					if (sampleUp) begin
						rxValid <= 1'b1;
						state <= HUNT;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == HUNT && syncFound)
			rxSync <= syncCmd ? SYNC_CMD : SYNC_DATA;
		// only the first half of each bit is kept, MSB arrives first.
		if (state == BITS && sampleUp) begin
			if (bitCnt == 5'(MIL_DATA_BITS))
				parityIn <= rxIn;
			else
				shiftReg <= {shiftReg[MIL_DATA_BITS-2:0], rxIn};
		end
		if (state == PEND && sampleUp) begin
			rxWord <= shiftReg;
			rxParityError <= ~^{shiftReg, parityIn};
		end
	end

endmodule

/* hw/milTerminal.sv */
module milTerminal (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       ioClk,
	input  logic                       enable,
	input  logic                       pushValid,
	input  milStd1553Pkg::MilWordType  pushType,
	input  logic [15:0]                pushWord,
	input  logic                       rxIn,
	input  logic                       nRxIn,
	output logic                       credit,
	output logic                       txOut,
	output logic                       nTxOut,
	output logic                       isBusy,
	output logic                       rxValid,
	output milStd1553Pkg::MilSync      rxSync,
	output logic [15:0]                rxWord,
	output logic                       rxParityError
);
	import milStd1553Pkg::*;

	logic up;
	logic down;
	logic qAvail;
	logic take;
	MilData qData;

	// one edge detector serves both directions.
	ioClkEdges edges (
		.clk   (clk),
		.rst   (rst),
		.ioClk (ioClk),
		.up    (up),
		.down  (down)
	);

	milTxQueue queue (
		.clk       (clk),
		.rst       (rst),
		.pushValid (pushValid),
		.pushType  (pushType),
		.pushWord  (pushWord),
		.take      (take),
		.qData     (qData),
		.qAvail    (qAvail),
		.credit    (credit)
	);

	milTransmitter tx (
		.clk    (clk),
		.rst    (rst),
		.up     (up),
		.down   (down),
		.enable (enable),
		.qData  (qData),
		.qAvail (qAvail),
		.take   (take),
		.txOut  (txOut),
		.nTxOut (nTxOut),
		.isBusy (isBusy)
	);

	milReceiver rx (
		.clk           (clk),
		.rst           (rst),
		.up            (up),
		.down          (down),
		.rxIn          (rxIn),
		.nRxIn         (nRxIn),
		.rxValid       (rxValid),
		.rxSync        (rxSync),
		.rxWord        (rxWord),
		.rxParityError (rxParityError)
	);

endmodule

/* tb/milTerminal_sva.sv */
module milTerminalSva (
	input logic clk,
	input logic rst,
	input logic enable,
	input logic take,
	input logic qAvail,
	input logic credit,
	input logic txOut,
	input logic nTxOut
);
	timeunit 1ns;
	timeprecision 1ps;

	int failCount = 0;

	lineExclusive: assert property (@(posedge clk) disable iff (rst) !(txOut && nTxOut))
		else begin
			failCount++;
			$error("txOut and nTxOut are both high");
		end

	// a credit goes out only in the cycle after a real pop.
	creditFromPop: assert property (@(posedge clk) disable iff (rst) credit |-> $past(take && qAvail))
		else begin
			failCount++;
			$error("credit pulsed without a pop");
		end

	lineOffWhenDisabled: assert property (@(posedge clk) disable iff (rst)
			!enable |-> (!txOut && !nTxOut))
		else begin
			failCount++;
			$error("line driven while enable is low");
		end

endmodule

bind milTerminal milTerminalSva sva (.*);

/* tb/milTerminalTb.sv */
`include "mil_defs.svh"

module milTerminalTb;
	timeunit 1ns;
	timeprecision 1ps;
	import milStd1553Pkg::*;
	import milLinkPkg::*;

	localparam int CLK_NS = 40;
	localparam int BIT_CYCLES = 16;
	localparam int BIT_NS = BIT_CYCLES * CLK_NS;
	localparam MilCredit FULL_CREDITS = MilCredit'(`MIL_QUEUE_DEPTH);

	logic clk = 1'b0;
	logic rst, ioClk, enable, pushValid, rxIn, nRxIn, credit, txOut, nTxOut, isBusy;
	logic rxValid, rxParityError, flip;
	logic [15:0] pushWord, rxWord;
	MilWordType pushType;
	MilSync rxSync;

	// one entry per trace line; stepExp is {sync, parity error, word} as it should come back.
	string stepName [$];
	int stepEnable [$];
	int stepType [$];
	int stepCorrupt [$];
	logic [15:0] stepWord [$];
	logic [17:0] stepExp [$];
	logic [17:0] expQ [$];
	MilCredit credits;
	int errors, checks, testsRun, testsBad;
	bit traceLoaded = 1'b0;

	// loopback wire that can invert one bit.
	assign rxIn = txOut ^ flip;
	assign nRxIn = nTxOut ^ flip;

	milTerminal i_milTerminal (.*);

	always #(CLK_NS / 2) clk = !clk;

	always begin
		repeat (BIT_CYCLES / 2) @(posedge clk);
		#5 ioClk = !ioClk;
	end

	task automatic loadTrace(output bit ok);
		int fd, n, en, typ, cor, syn, par;
		string lineText, name;
		logic [15:0] word;
		fd = $fopen("tb/milTerminal_trace.txt", "r");
		ok = (fd != 0);
		while (ok && !$feof(fd)) begin
			lineText = "";
			void'($fgets(lineText, fd));
			if (lineText.len() > 1 && lineText[0] != "#") begin
				n = $sscanf(lineText, "%s %d %d %h %d %d %d",
					name, en, typ, word, cor, syn, par);
				if (n != 7) begin
					$display("trace line not understood: %s", lineText);
					errors++;
				end else begin
					stepName.push_back(name);
					stepEnable.push_back(en);
					stepType.push_back(typ);
					stepWord.push_back(word);
					stepCorrupt.push_back(cor);
					// an inverted data bit comes back inverted.
					if (cor >= 0)
						word = word ^ (16'h1 << cor);
					stepExp.push_back({1'(syn), 1'(par), word});
				end
			end
		end
		if (ok)
			$fclose(fd);
	endtask

	task automatic reportMismatch(string what, logic [15:0] got, logic [15:0] want);
		$display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, want);
		errors++;
	endtask

	task automatic checkWord();
		logic [17:0] e;
		checks++;
		assert (enable) else begin
			$display("at %0t ns a word came in while the line was disabled", $time);
			errors++;
		end
		assert (expQ.size() != 0) else begin
			$display("at %0t ns word %h came in but no word was sent", $time, rxWord);
			errors++;
		end
		if (expQ.size() != 0) begin
			e = expQ.pop_front();
			assert (rxWord == e[15:0]) else reportMismatch("rxWord", rxWord, e[15:0]);
			assert (rxSync == MilSync'(e[17]))
				else reportMismatch("rxSync", 16'(rxSync), 16'(e[17]));
			assert (rxParityError == e[16])
				else reportMismatch("rxParityError", 16'(rxParityError), 16'(e[16]));
		end
	endtask

	task automatic monitorOutputs();
		forever begin
			@(negedge clk);
			if (credit)
				credits = credits + 1'b1;
			assert (credits <= FULL_CREDITS)
				else reportMismatch("credits", 16'(credits), 16'(FULL_CREDITS));
			if (rxValid)
				checkWord();
		end
	endtask

	// the sync starts on the line, then three sync bit times and the bits sent before this one.
	task automatic corruptBit(int bitPos);
		while (!(txOut || nTxOut)) @(negedge clk);
		repeat (3 + 15 - bitPos) @(posedge ioClk);
		flip = 1'b1;
		@(posedge ioClk);
		flip = 1'b0;
	endtask

	task automatic pushStep(int s);
		repeat ($urandom_range(3, 0)) @(posedge clk);
		while (credits == 0) @(negedge clk);
		@(posedge clk);
		#5;
		enable = (stepEnable[s] != 0);
		pushValid = 1'b1;
		pushType = MilWordType'(stepType[s]);
		pushWord = stepWord[s];
		credits = credits - 1'b1;
		if (stepType[s] != 0)
			expQ.push_back(stepExp[s]);
		@(posedge clk);
		#5;
		pushValid = 1'b0;
		if (stepCorrupt[s] >= 0)
			corruptBit(stepCorrupt[s]);
	endtask

	task automatic finishTest(int first, int last, int errBefore);
		if (stepEnable[last] != 0) begin
			while (expQ.size() != 0 || isBusy) @(negedge clk);
			repeat (2 * BIT_CYCLES) @(negedge clk);
			assert (credits == FULL_CREDITS)
				else reportMismatch("credits", 16'(credits), 16'(FULL_CREDITS));
		end else begin
			// words stay queued while the line is off.
			repeat (8 * BIT_CYCLES) @(negedge clk);
			// no word may start while enable is low.
			assert (!isBusy) else reportMismatch("isBusy", 16'(isBusy), 16'h0);
		end
		testsRun++;
		if (errors != errBefore)
			testsBad++;
		$display("%-10s %0d words  %s", stepName[first], last - first + 1,
			(errors == errBefore) ? "ok" : "with errors");
	endtask

	initial begin
		bit ok;
		int s, first, errBefore;
		rst = 1'b1;
		ioClk = 1'b0;
		enable = 1'b0;
		pushValid = 1'b0;
		pushType = WERROR;
		pushWord = '0;
		flip = 1'b0;
		credits = FULL_CREDITS;
		{errors, checks, testsRun, testsBad} = '0;
		void'($urandom(27875));
		loadTrace(ok);
		if (!ok || stepName.size() == 0) begin
			$display("could not read tb/milTerminal_trace.txt");
			$display("Test failed");
			$finish;
		end else begin
			traceLoaded = 1'b1;
			repeat (3) @(posedge clk);
			#5 rst = 1'b0;
			fork
				monitorOutputs();
			join_none
			s = 0;
			while (s < stepName.size()) begin
				first = s;
				errBefore = errors;
				while (s < stepName.size() && stepName[s] == stepName[first]) begin
					pushStep(s);
					s++;
				end
				finishTest(first, s - 1, errBefore);
			end
			errors += i_milTerminal.sva.failCount;
			$display("%0d tests, %0d with errors, %0d words checked, %0d errors",
				testsRun, testsBad, checks, errors);
			if (errors == 0) begin
				$display("Test completed successfully");
			end else begin
				$display("Test failed");
			end
			$finish;
		end
	end

	// each trace line gets 25 bit times.
	initial begin
		wait (traceLoaded);
		#(stepName.size() * 25 * BIT_NS);
		$display("watchdog expired after %0d bit times, the run did not finish",
			stepName.size() * 25);
		$display("Test failed");
		$finish;
	end

endmodule

/* milTerminal.f */
+incdir+hw
hw/milStd1553Pkg.sv
hw/milLinkPkg.sv
hw/ioClkEdges.sv
hw/milTxQueue.sv
hw/milTransmitter.sv
hw/milReceiver.sv
hw/milTerminal.sv
tb/milTerminal_sva.sv
tb/milTerminalTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= milTerminalTb
FILELIST  ?= milTerminal.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_TEXT ?= Test completed successfully
SOURCES   := $(wildcard hw/*.sv hw/*.svh tb/*.sv) tb/milTerminal_trace.txt

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb/milTerminal_trace.txt */
# name enable type word corrupt sync parityError
# type 0 error 1 data 2 command 3 status, corrupt is the bit to invert or -1, sync 0 cmd 1 data
data     1 1 a5c3 -1 1 0
data     1 1 0000 -1 1 0
cmdStat  1 2 1234 -1 0 0
cmdStat  1 3 ffff -1 0 0
error    1 0 dead -1 0 0
error    1 1 0f0f -1 1 0
burst    1 1 0001 -1 1 0
burst    1 2 8000 -1 0 0
burst    1 3 7ffe -1 0 0
burst    1 1 5a5a -1 1 0
disabled 0 1 c001 -1 1 0
disabled 0 2 0c30 -1 0 0
enabled  1 1 3c3c -1 1 0
corrupt  1 1 1357 5 1 1
